// ==== dense_input.txt ====
# test <name> <in_words> <out_count> <relu_en> <shift>, vec <128-bit hex, element 15 first>
# param <start addr hex> <word count> <words hex>, run <best_index> <expected value per output>

test bias_only 1 3 0 2
vec 01010101010101010101010101010101
param 00 2 00000064 00000000
param 02 2 ffffffd8 00000000
param 04 2 000003e8 00000000
run 2 25 -10 127

test dot_four_words 4 2 0 0
vec 100f0e0d0c0b0a090807060504030201
param 00 5 00000005 01010101 00000000 000000ff 02000000
param 05 5 fffffff6 00000000 0000fd02 00000000 00ff0000
run 0 38 -33

test relu_clamp_high 2 4 1 1
vec 000000000000000002019c640003fb0a
param 00 3 ffffffce 01010101 00000000
param 03 3 00000014 00000002 00000000
param 06 3 00000000 00000000 0000007f
param 09 3 00000000 00000000 0000ff00
run 2 0 20 127 50

test clamp_low 1 3 0 0
vec 00000000000000000000000000000080
param 00 2 00000000 0000007f
param 02 2 00000003 00000000
param 04 2 fffffffb 000000ff
run 2 -128 3 123

test argmax_tie 1 4 0 0
vec 00000000000000000000000000000000
param 00 2 00000007 00000000
param 02 2 00000009 00000000
param 04 2 00000009 00000000
param 06 2 fffffffe 00000000
run 1 7 9 9 -2

test three_words_relu 3 1 1 3
vec 00000000000008080000000001020304
param 00 4 00000004 04030201 00000000 0000ffff
run 0 1

// ==== src.f ====
+incdir+.
dense_pkg.sv
param_store.sv
weight_sequencer.sv
mac_execute.sv
result_stage.sv
dense_engine.sv
dense_engine_asserts.sv
tb_dense_engine.sv

// ==== tb_dense_engine.sv ====
`include "dense_consts.svh"

module tb_dense_engine;

    import dense_pkg::*;

    logic                     clk;
    logic                     reset;
    logic                     load_en;
    logic [`DENSE_ADDR_W-1:0] load_addr;
    param_word_t              load_word;
    logic                     start;
    cmd_t                     cmd;
    vec_t                     vec;
    logic                     busy;
    logic                     result_valid;
    logic [`DENSE_IDX_W-1:0]  result_index;
    int8_t                    result_value;
    logic [`DENSE_IDX_W-1:0]  best_index;
    logic                     done;

    int    fd;
    int    budget = 20;   // Watchdog limit in cycles that grows as tests are read
    int    tests_run = 0;
    string test_name = "reset";
    cmd_t  cur_cmd;                        // Command of the test being read
    vec_t  cur_vec;
    int    exp_value [`DENSE_MAX_OUT];     // Expected result per output index

    dense_engine i_dut (
        .clk(clk)
        ,.reset(reset)
        ,.load_en(load_en)
        ,.load_addr(load_addr)
        ,.load_word(load_word)
        ,.start(start)
        ,.cmd(cmd)
        ,.vec(vec)
        ,.busy(busy)
        ,.result_valid(result_valid)
        ,.result_index(result_index)
        ,.result_value(result_value)
        ,.best_index(best_index)
        ,.done(done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // Period 20
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(string what, int expected, int actual);
        $display("Error in %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
        $display(">>> FAIL");
        $fatal(1, "check failed");
    endtask

    // Watchdog
    initial begin
        int elapsed;
        elapsed = 0;
        while (elapsed < budget) begin
            @(posedge clk);
            elapsed++;
        end
        abort_run($sformatf("Run timed out after %0d cycles without finishing", elapsed));
    end

    // Protocol checker bound into the DUT
    initial begin
        wait (i_dut.i_asserts.fail_count != 0);
        abort_run($sformatf("Protocol assertion on the DUT ports failed in %s", test_name));
    end

    // ========================================
    // Parameter load and run
    // ========================================
    // Consecutive words from a start address at one word per cycle
    task automatic load_channel();
        int          addr;
        int          n;
        logic [31:0] word_raw;
        void'($fscanf(fd, "%h %d", addr, n));
        budget += n;
        for (int i = 0; i < n; i++) begin
            void'($fscanf(fd, "%h", word_raw));
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= addr[`DENSE_ADDR_W-1:0] + i[`DENSE_ADDR_W-1:0];
            load_word <= word_raw;
        end
    endtask

    task automatic run_test();
        int          best;
        int          seen;
        int          n_out;
        logic [31:0] noise;
        logic        finished;
        n_out = int'(cur_cmd.out_count);
        void'($fscanf(fd, "%d", best));
        for (int i = 0; i < n_out; i++) begin
            void'($fscanf(fd, "%d", exp_value[i]));
        end
        budget += n_out * (1 + int'(cur_cmd.in_words)) + 30;  // Reads plus pipeline and gaps
        @(posedge clk);
        load_en <= 1'b0;
        start   <= 1'b1;
        cmd     <= cur_cmd;
        vec     <= cur_vec;
        @(posedge clk);
        noise = $urandom;
        start <= 1'b0;
        cmd   <= noise[$bits(cmd_t)-1:0];                  // Captured copy must hold
        vec   <= {$urandom, $urandom, $urandom, $urandom};
        @(posedge clk);
        start <= 1'b1;  // Ignored since busy is already high
        @(posedge clk);
        start <= 1'b0;
        seen     = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (result_valid) begin
                assert (seen < n_out)
                    else abort_run($sformatf("More results than outputs in %s", test_name));
                assert (int'(result_index) == seen)
                    else report_mismatch("result_index", seen, int'(result_index));
                assert (int'(result_value) == exp_value[seen])
                    else report_mismatch($sformatf("result_value[%0d]", seen),
                                         exp_value[seen], int'(result_value));
                seen++;
            end
            finished = done;
        end
        assert (seen == n_out) else report_mismatch("result count", n_out, seen);
        assert (int'(best_index) == best)
            else report_mismatch("best_index", best, int'(best_index));
        // A second done would show in the idle gap
        repeat ($urandom_range(1, 6)) begin
            @(negedge clk);
            assert (!busy && !result_valid && !done)
                else abort_run($sformatf("Engine still active after done in %s", test_name));
        end
        tests_run++;
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        string               tok;
        logic [8*128-1:0]    line_buf;
        int                  n_in;
        int                  n_out;
        int                  relu;
        int                  shift_amt;
        logic [127:0]        vec_raw;
        void'($urandom(32'hf285));
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_word = '0;
        start     = 1'b0;
        cmd       = '0;
        vec       = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!busy && !result_valid && !done)
            else abort_run("busy, result_valid or done high right after reset");
        assert (best_index == '0) else report_mismatch("best_index", 0, int'(best_index));
        fd = $fopen("dense_input.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open dense_input.txt");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                void'($fgets(line_buf, fd));  // Rest of a comment line
            end else if (tok == "test") begin
                void'($fscanf(fd, "%s %d %d %d %d", test_name, n_in, n_out, relu, shift_amt));
                cur_cmd.in_words  = n_in[`DENSE_INW_W-1:0];
                cur_cmd.out_count = n_out[`DENSE_CNT_W-1:0];
                cur_cmd.relu_en   = relu[0];
                cur_cmd.shift     = shift_amt[`DENSE_SHIFT_W-1:0];
            end else if (tok == "vec") begin
                void'($fscanf(fd, "%h", vec_raw));
                cur_vec = vec_raw;
            end else if (tok == "param") begin
                load_channel();
            end else if (tok == "run") begin
                run_test();
            end else begin
                abort_run($sformatf("Unknown keyword %s in dense_input.txt", tok));
            end
        end
        $fclose(fd);
        if (tests_run == 0) begin
            abort_run("No tests found in dense_input.txt");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== dense_engine_asserts.sv ====
module dense_engine_asserts (
    input logic clk
    ,input logic reset
    ,input logic busy
    ,input logic result_valid
    ,input logic done
);

    int fail_count = 0;  // Failed assertions so far

    // ========================================
    // Port protocol
    // ========================================
    a_done_with_result: assert property (@(posedge clk) disable iff (reset)
        done |-> result_valid)  // Done rides on the final result
        else begin
            $error("done without result_valid");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else begin
            $error("done held longer than one cycle");
            fail_count++;
        end

    a_result_in_run: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> $past(busy))  // Results only come out of a run
        else begin
            $error("result_valid without busy in the previous cycle");
            fail_count++;
        end

    a_idle_after_done: assert property (@(posedge clk) disable iff (reset)
        done |=> !busy)
        else begin
            $error("busy still high after done");
            fail_count++;
        end

endmodule

bind dense_engine dense_engine_asserts i_asserts (
    .clk(clk)
    ,.reset(reset)
    ,.busy(busy)
    ,.result_valid(result_valid)
    ,.done(done)
);

// ==== dense_engine.sv ====
`include "dense_consts.svh"

module dense_engine (
    input logic clk
    ,input logic reset

    // Parameter load, only while idle
    ,input logic                      load_en
    ,input logic [`DENSE_ADDR_W-1:0]  load_addr
    ,input dense_pkg::param_word_t    load_word

    // Command
    ,input logic                      start
    ,input dense_pkg::cmd_t           cmd
    ,input dense_pkg::vec_t           vec

    ,output logic                     busy
    ,output logic                     result_valid
    ,output logic [`DENSE_IDX_W-1:0]  result_index
    ,output dense_pkg::int8_t         result_value
    ,output logic [`DENSE_IDX_W-1:0]  best_index
    ,output logic                     done
);

    import dense_pkg::*;

    logic [`DENSE_ADDR_W-1:0] rd_addr;
    param_word_t              rd_word;
    op_t                      op;       // Decode to execute
    acc_t                     acc;      // Execute to result
    cmd_t                     run_cmd;
    vec_t                     run_vec;

    // ========================================
    // Memory and decode
    // ========================================
    param_store i_store (
        .clk(clk)
        ,.we(load_en)
        ,.waddr(load_addr)
        ,.wdata(load_word)
        ,.raddr(rd_addr)
        ,.rdata(rd_word)
    );

    weight_sequencer i_seq (
        .clk(clk)
        ,.reset(reset)
        ,.start(start)
        ,.cmd(cmd)
        ,.vec(vec)
        ,.done(done)        // Ends busy
        ,.raddr(rd_addr)
        ,.rdata(rd_word)
        ,.op(op)
        ,.run_cmd(run_cmd)
        ,.run_vec(run_vec)
        ,.busy(busy)
    );

    // ========================================
    // Execute and result
    // ========================================
    mac_execute i_mac (
        .clk(clk)
        ,.reset(reset)
        ,.op(op)
        ,.vec(run_vec)
        ,.out_count(run_cmd.out_count)
        ,.acc_out(acc)
    );

    result_stage i_result (
        .clk(clk)
        ,.reset(reset)
        ,.acc_in(acc)
        ,.relu_en(run_cmd.relu_en)
        ,.shift(run_cmd.shift)
        ,.result_valid(result_valid)
        ,.result_index(result_index)
        ,.result_value(result_value)
        ,.best_index(best_index)
        ,.done(done)
    );

endmodule

// ==== result_stage.sv ====
`include "dense_consts.svh"

module result_stage (
    input logic clk
    ,input logic reset

    ,input dense_pkg::acc_t acc_in
    ,input logic                      relu_en
    ,input logic [`DENSE_SHIFT_W-1:0] shift

    ,output logic                       result_valid
    ,output logic [`DENSE_IDX_W-1:0]    result_index
    ,output dense_pkg::int8_t           result_value
    ,output logic [`DENSE_IDX_W-1:0]    best_index    // Argmax of the last run
    ,output logic                       done
);

    import dense_pkg::*;

    logic signed [`DENSE_ACC_W-1:0] relu_val;
    logic signed [`DENSE_ACC_W-1:0] shifted;
    int8_t                          sat_val;
    logic                           new_best;

    // Running maximum over the current run
    int8_t                          best_val;
    logic [`DENSE_IDX_W-1:0]        best_idx;

    // ========================================
    // ReLU, requant shift, saturation
    // ========================================
    always_comb begin
        if (relu_en && acc_in.acc[`DENSE_ACC_W-1]) begin
            relu_val = '0;  // Negative sum cleared
        end else begin
            relu_val = acc_in.acc;
        end
        shifted = relu_val >>> shift;  // Arithmetic, keeps sign
        if (shifted > 32'sd127) begin
            sat_val = 8'sd127;
        end else if (shifted < -32'sd128) begin
            sat_val = -8'sd128;
        end else begin
            sat_val = shifted[7:0];
        end
        // Index 0 restarts the search, strict compare so lowest index wins ties
        new_best = (acc_in.out_idx == '0) || (sat_val > best_val);
    end

    // Result payload and running max
    always_ff @(posedge clk) begin
        if (acc_in.valid) begin
            result_index <= acc_in.out_idx;
            result_value <= sat_val;
            if (new_best) begin
                best_val <= sat_val;
                best_idx <= acc_in.out_idx;
            end
        end
    end

    // Strobes and argmax report
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            done         <= 1'b0;
            best_index   <= '0;
        end else begin
            result_valid <= acc_in.valid;
            done         <= acc_in.valid && acc_in.last_out;  // With final result
            if (acc_in.valid && acc_in.last_out) begin
                best_index <= new_best ? acc_in.out_idx : best_idx;
            end
        end
    end

endmodule

// ==== mac_execute.sv ====
`include "dense_consts.svh"

module mac_execute (
    input logic clk
    ,input logic reset

    ,input dense_pkg::op_t  op
    ,input dense_pkg::vec_t vec                        // Held for the whole run
    ,input logic [`DENSE_CNT_W-1:0] out_count

    ,output dense_pkg::acc_t acc_out
);

    import dense_pkg::*;

    logic signed [`DENSE_ACC_W-1:0] lane_sum;   // Four products of this word
    logic signed [`DENSE_ACC_W-1:0] acc_next;
    logic signed [`DENSE_ACC_W-1:0] acc_q;      // Running sum, holds the result after last
    logic                           out_valid;
    logic                           out_last;
    logic [`DENSE_IDX_W-1:0]        out_idx;

    // ========================================
    // Lane products
    // ========================================
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < `DENSE_LANES; l++) begin
            // Signed int8 x int8, extended to accumulator width
            lane_sum = lane_sum + op.word.weights[l] * vec[op.word_sel*`DENSE_LANES + l];
        end
        if (op.kind == OP_BIAS) begin
            acc_next = op.word.bias;  // Start of a new output
        end else begin
            acc_next = acc_q + lane_sum;
        end
    end

    // Running sum and index of the output in progress
    always_ff @(posedge clk) begin
        if (op.valid) begin
            acc_q   <= acc_next;
            out_idx <= op.out_idx;
        end
    end

    // One strobe per finished output
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= op.valid && op.last;
            out_last  <= op.valid && op.last &&
                         ({1'b0, op.out_idx} == out_count - 1'b1);  // Final channel
        end
    end

    assign acc_out = '{valid: out_valid, last_out: out_last, out_idx: out_idx, acc: acc_q};

endmodule

// ==== weight_sequencer.sv ====
`include "dense_consts.svh"

module weight_sequencer (
    input logic clk
    ,input logic reset

    ,input logic              start     // One-cycle pulse
    ,input dense_pkg::cmd_t   cmd
    ,input dense_pkg::vec_t   vec
    ,input logic              done      // End of run from the result stage

    ,output logic [`DENSE_ADDR_W-1:0] raddr
    ,input  dense_pkg::param_word_t   rdata

    ,output dense_pkg::op_t   op
    ,output dense_pkg::cmd_t  run_cmd   // Captured command for execute and result
    ,output dense_pkg::vec_t  run_vec   // Captured input vector
    ,output logic             busy
);

    import dense_pkg::*;

    logic                     start_ok;
    logic                     running;   // Issuing reads
    logic [`DENSE_INW_W-1:0]  word_cnt;  // 0 is the bias word
    logic [`DENSE_IDX_W-1:0]  out_cnt;

    // Tag of the read in flight, lines up with rdata
    logic                     tag_valid;
    op_kind_t                 tag_kind;
    logic                     tag_last;
    logic [`DENSE_WSEL_W-1:0] tag_sel;
    logic [`DENSE_IDX_W-1:0]  tag_idx;

    // Operation register toward execute
    logic                     op_valid;
    op_kind_t                 op_kind;
    logic                     op_last;
    logic [`DENSE_WSEL_W-1:0] op_sel;
    logic [`DENSE_IDX_W-1:0]  op_idx;
    param_word_t              op_word;

    assign start_ok = start && !busy;  // Start ignored during a run

    // Command and vector capture
    always_ff @(posedge clk) begin
        if (start_ok) begin
            run_cmd <= cmd;
            run_vec <= vec;
        end
    end

    // ========================================
    // Read address walk
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            running  <= 1'b0;
            raddr    <= '0;
            word_cnt <= '0;
            out_cnt  <= '0;
        end else begin
            if (start_ok) begin
                busy     <= 1'b1;
                running  <= 1'b1;
                raddr    <= '0;  // Channel 0 bias
                word_cnt <= '0;
                out_cnt  <= '0;
            end else if (running) begin
                raddr <= raddr + 1'b1;  // Layout is contiguous across channels
                if (word_cnt == run_cmd.in_words) begin
                    word_cnt <= '0;
                    out_cnt  <= out_cnt + 1'b1;
                    if ({1'b0, out_cnt} == run_cmd.out_count - 1'b1) begin
                        running <= 1'b0;  // Last read of the run
                    end
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
            if (done) begin
                busy <= 1'b0;  // Pipeline drained
            end
        end
    end

    // Valid flags, tag then operation
    always_ff @(posedge clk) begin
        if (reset) begin
            tag_valid <= 1'b0;
            op_valid  <= 1'b0;
        end else begin
            tag_valid <= running;
            op_valid  <= tag_valid;
        end
    end

    // Tag fields and pairing with the returned word
    always_ff @(posedge clk) begin
        tag_kind <= (word_cnt == '0) ? OP_BIAS : OP_WEIGHT;
        tag_last <= (word_cnt == run_cmd.in_words);
        tag_sel  <= word_cnt[`DENSE_WSEL_W-1:0] - 1'b1;  // Weight word n uses vector word n-1
        tag_idx  <= out_cnt;
        op_kind  <= tag_kind;
        op_last  <= tag_last;
        op_sel   <= tag_sel;
        op_idx   <= tag_idx;
        op_word  <= rdata;  // Read as bias or weights by kind
    end

    assign op = '{valid: op_valid, kind: op_kind, last: op_last, word_sel: op_sel,
                  out_idx: op_idx, word: op_word};

endmodule

// ==== param_store.sv ====
`include "dense_consts.svh"

module param_store (
    input logic clk

    // Load port
    ,input logic                     we
    ,input logic [`DENSE_ADDR_W-1:0] waddr
    ,input dense_pkg::param_word_t   wdata

    // Read port, data one cycle later
    ,input  logic [`DENSE_ADDR_W-1:0] raddr
    ,output dense_pkg::param_word_t   rdata
);

    import dense_pkg::*;

    // Bias and weight words, block memory style
    param_word_t mem [`DENSE_PARAM_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== dense_pkg.sv ====
`include "dense_consts.svh"

package dense_pkg;

    typedef logic signed [7:0] int8_t;

    // ========================================
    // Parameter memory word
    // ========================================
    // Bias word at the head of each output channel, weight words behind it
    typedef union packed {
        logic signed [`DENSE_ACC_W-1:0] bias;     // One int32 bias
        int8_t [`DENSE_LANES-1:0]       weights;  // Lane 0 in the low byte
    } param_word_t;

    // Run command, captured on start
    typedef struct packed {
        logic [`DENSE_INW_W-1:0]   in_words;   // Input length in 4-lane words
        logic [`DENSE_CNT_W-1:0]   out_count;  // Number of outputs
        logic                      relu_en;    // Clear negative sums
        logic [`DENSE_SHIFT_W-1:0] shift;      // Arithmetic right shift
    } cmd_t;

    typedef enum logic {
        OP_BIAS,
        OP_WEIGHT
    } op_kind_t;

    // Decode to execute
    typedef struct packed {
        logic                     valid;
        op_kind_t                 kind;
        logic                     last;      // Final word of this output
        logic [`DENSE_WSEL_W-1:0] word_sel;  // Vector word paired with the weights
        logic [`DENSE_IDX_W-1:0]  out_idx;
        param_word_t              word;
    } op_t;

    // Execute to result, one per finished output
    typedef struct packed {
        logic                           valid;
        logic                           last_out;  // Final output of the run
        logic [`DENSE_IDX_W-1:0]        out_idx;
        logic signed [`DENSE_ACC_W-1:0] acc;
    } acc_t;

    typedef int8_t [`DENSE_LANES*`DENSE_MAX_IN_WORDS-1:0] vec_t;  // Element 0 in low byte

endpackage

// ==== dense_consts.svh ====
`ifndef DENSE_CONSTS_SVH
`define DENSE_CONSTS_SVH

// ========================================
// Engine dimensions
// ========================================
`define DENSE_LANES         4   // int8 lanes per parameter word
`define DENSE_MAX_IN_WORDS  4   // 16-element input vector at most
`define DENSE_MAX_OUT       8   // Output channels per run
`define DENSE_PARAM_DEPTH   64  // Covers 8 x (1 bias + 4 weight words)
`define DENSE_ACC_W         32  // Accumulator and bias width
`define DENSE_SHIFT_W       5   // Requant shift field

// Derived field widths
`define DENSE_ADDR_W  $clog2(`DENSE_PARAM_DEPTH)       // Parameter memory address
`define DENSE_IDX_W   $clog2(`DENSE_MAX_OUT)           // Output index
`define DENSE_CNT_W   $clog2(`DENSE_MAX_OUT + 1)       // Output count, 1..8
`define DENSE_WSEL_W  $clog2(`DENSE_MAX_IN_WORDS)      // Vector word select
`define DENSE_INW_W   $clog2(`DENSE_MAX_IN_WORDS + 1)  // Input length, 1..4

`endif
